/* verification/mastermind_golden.txt */
# Record C: code colours for slots 0 1 2 3
# Record G: guess colours for slots 0 1 2 3, expected red, expected white
# Record N: new game strobe
C 1 2 3 4
G 1 2 4 3 2 2
G 5 5 5 5 0 0
G 1 1 1 1 1 0
G 1 2 3 4 4 0
# Second round, eight guesses without a win
C 2 2 3 3
G 3 3 2 2 0 4
G 2 3 2 3 2 2
G 2 0 0 2 1 1
G 0 0 0 0 0 0
G 7 3 3 2 1 2
G 3 2 3 6 2 1
G 2 2 3 1 3 0
G 4 4 4 4 0 0
C 6 6 0 7
G 6 0 6 6 1 2
N
C 5 4 3 2
G 2 3 4 5 0 4
G 5 4 3 2 4 0

/* list.f */
+incdir+hw
hw/mastermind_pkg.sv
hw/game_ctrl.sv
hw/peg_store.sv
hw/exact_match_counter.sv
hw/colour_match_counter.sv
hw/feedback_combiner.sv
hw/mastermind_top.sv
verification/mastermind_chk.sv
verification/mastermind_tb.sv

/* Bender.yml */
package:
  name: mastermind

sources:
  - include_dirs:
      - hw
    files:
      - hw/mastermind_pkg.sv
      - hw/game_ctrl.sv
      - hw/peg_store.sv
      - hw/exact_match_counter.sv
      - hw/colour_match_counter.sv
      - hw/feedback_combiner.sv
      - hw/mastermind_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/mastermind_chk.sv
      - verification/mastermind_tb.sv

/* verification/mastermind_tb.sv */
`timescale 1ns/100ps
`include "mastermind_cfg.svh"

module mastermind_tb
    import mastermind_pkg::*;
();

    localparam int FEEDBACK_TIMEOUT = 20;

    logic       clock;
    logic       resetn;
    logic       load_i;
    logic       new_game_i;
    peg_t       colour_i;
    peg_count_t red_o;
    peg_count_t white_o;
    logic       feedback_valid_o;
    score_t     score_one_o;
    score_t     score_two_o;
    logic       one_sets_code_o;

    // Score model
    score_t exp_score_one;
    score_t exp_score_two;
    logic   exp_one_sets;
    int     guess_cnt;

    int checks;
    int errors;
    int aborts;

    mastermind_top i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic check_value(input int got, input int expected, input string what);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("FAILED at time %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    // Press, hold for a random time, release until the release edge
    task automatic enter_peg(input peg_t colour);
        int hold;
        hold     = 1 + ($urandom % 12);
        colour_i = colour;
        load_i   = 1'b1;
        repeat (hold) begin
            @(posedge clock);
            #2;
        end
        load_i = 1'b0;
        @(posedge clock);
        #2;
    endtask

    task automatic wait_feedback(output int cycles, output bit ok);
        cycles = 0;
        while (!feedback_valid_o && cycles < FEEDBACK_TIMEOUT) begin
            @(posedge clock);
            #2;
            cycles++;
        end
        ok = feedback_valid_o;
        if (!ok) begin
            $display("Timeout: no feedback pulse within %0d cycles at time %0t", cycles, $time);
        end
    endtask

    task automatic check_state(input int exp_red, input int exp_white, input string when);
        check_value(red_o, exp_red, {"red_o ", when});
        check_value(white_o, exp_white, {"white_o ", when});
        check_value(score_one_o, exp_score_one, {"score_one_o ", when});
        check_value(score_two_o, exp_score_two, {"score_two_o ", when});
        check_value(one_sets_code_o, exp_one_sets, {"one_sets_code_o ", when});
    endtask

    // One-cycle strobe, model back to a fresh game
    task automatic start_new_game();
        new_game_i = 1'b1;
        @(posedge clock);
        #2;
        new_game_i    = 1'b0;
        exp_score_one = '0;
        exp_score_two = '0;
        exp_one_sets  = 1'b1;
        guess_cnt     = 0;
        check_state(0, 0, "after new game");
    endtask

    initial begin
        int               fd;
        int               n;
        int               cycles;
        int               pegs[`MM_SLOTS];
        int               exp_red;
        int               exp_white;
        bit               ok;
        bit               done;
        logic [63:0]      tag;
        logic [8*160-1:0] skipped_line;

        resetn     = 1'b0;
        load_i     = 1'b0;
        new_game_i = 1'b0;
        colour_i   = '0;
        checks     = 0;
        errors     = 0;
        aborts     = 0;
        void'($urandom(29876));

        exp_score_one = '0;
        exp_score_two = '0;
        exp_one_sets  = 1'b1;
        guess_cnt     = 0;

        repeat (5) @(posedge clock);
        #2;
        resetn = 1'b1;
        check_state(0, 0, "after reset");
        check_value(feedback_valid_o, 0, "feedback_valid_o after reset");

        fd = $fopen("verification/mastermind_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file verification/mastermind_golden.txt");
            aborts++;
        end else begin
            done = 1'b0;
            while (!done) begin
                n = $fscanf(fd, "%s", tag);
                if (n != 1) begin
                    done = 1'b1;
                end else if (tag == "#") begin
                    n = $fgets(skipped_line, fd);
                end else if (tag == "C") begin
                    n = $fscanf(fd, "%d %d %d %d", pegs[0], pegs[1], pegs[2], pegs[3]);
                    for (int i = 0; i < `MM_SLOTS; i++) begin
                        enter_peg(peg_t'(pegs[i]));
                    end
                end else if (tag == "G") begin
                    n = $fscanf(fd, "%d %d %d %d %d %d", pegs[0], pegs[1], pegs[2], pegs[3],
                                exp_red, exp_white);
                    for (int i = 0; i < `MM_SLOTS; i++) begin
                        enter_peg(peg_t'(pegs[i]));
                    end
                    wait_feedback(cycles, ok);
                    if (!ok) begin
                        aborts++;
                        done = 1'b1;
                    end else begin
                        check_value(cycles, 5, "feedback latency in cycles");
                        // Setter earns a point for every guess that misses
                        if (exp_red != `MM_SLOTS) begin
                            if (exp_one_sets) exp_score_one++;
                            else exp_score_two++;
                        end
                        guess_cnt++;
                        if (exp_red == `MM_SLOTS || guess_cnt == `MM_MAX_GUESSES) begin
                            guess_cnt    = 0;
                            exp_one_sets = !exp_one_sets;
                        end
                        check_state(exp_red, exp_white, "after guess");
                    end
                end else if (tag == "N") begin
                    start_new_game();
                end else begin
                    $display("Unknown record in the golden file at time %0t", $time);
                    aborts++;
                    done = 1'b1;
                end
            end
            $fclose(fd);

            // Player two sets here and a score is nonzero
            start_new_game();
        end

        $display("Checks: %0d, errors: %0d, aborted runs: %0d", checks, errors, aborts);
        if (errors == 0 && aborts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verification/mastermind_chk.sv */
`timescale 1ns/100ps
`include "mastermind_cfg.svh"

module mastermind_chk
    import mastermind_pkg::*;
(
    input logic       clock,
    input logic       resetn,
    input peg_count_t red_i,
    input peg_count_t white_i,
    input logic       feedback_valid_i
);

    // At most one peg of feedback per slot
    peg_sum_a: assert property (@(posedge clock) disable iff (!resetn)
        (int'(red_i) + int'(white_i)) <= `MM_SLOTS)
        else $error("red plus white exceeds the slot count");

    win_no_white_a: assert property (@(posedge clock) disable iff (!resetn)
        (red_i == peg_count_t'(`MM_SLOTS)) |-> (white_i == '0))
        else $error("white pegs reported with four red");

    valid_pulse_a: assert property (@(posedge clock) disable iff (!resetn)
        feedback_valid_i |=> !feedback_valid_i)
        else $error("feedback_valid_o high for two cycles");

    // Checked across reset, so no disable
    valid_after_reset_a: assert property (@(posedge clock)
        !resetn |=> !feedback_valid_i)
        else $error("feedback_valid_o high right after reset");

endmodule

bind mastermind_top mastermind_chk i_chk (
    .clock            (clock),
    .resetn           (resetn),
    .red_i            (red_o),
    .white_i          (white_o),
    .feedback_valid_i (feedback_valid_o)
);

/* hw/mastermind_top.sv */
`timescale 1ns/100ps

module mastermind_top
    import mastermind_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  logic       load_i,
    input  peg_t       colour_i,
    input  logic       new_game_i,
    output peg_count_t red_o,
    output peg_count_t white_o,
    output logic       feedback_valid_o,
    output score_t     score_one_o,
    output score_t     score_two_o,
    output logic       one_sets_code_o
);

    step_ctrl_t ctrl;
    logic       round_over;
    peg_t       code_peg;
    code_t      guess;
    peg_count_t red_count;
    peg_count_t match_count;

    game_ctrl i_ctrl (
        .clock        (clock),
        .resetn       (resetn),
        .load_i       (load_i),
        .new_game_i   (new_game_i),
        .round_over_i (round_over),
        .ctrl_o       (ctrl)
    );

    peg_store i_store (
        .clock      (clock),
        .resetn     (resetn),
        .ctrl_i     (ctrl),
        .colour_i   (colour_i),
        .code_peg_o (code_peg),
        .guess_o    (guess)
    );

    // Red and colour matches counted side by side
    exact_match_counter i_exact (
        .clock       (clock),
        .resetn      (resetn),
        .ctrl_i      (ctrl),
        .code_peg_i  (code_peg),
        .guess_i     (guess),
        .red_count_o (red_count)
    );

    colour_match_counter i_colour (
        .clock         (clock),
        .resetn        (resetn),
        .ctrl_i        (ctrl),
        .code_peg_i    (code_peg),
        .guess_i       (guess),
        .match_count_o (match_count)
    );

    feedback_combiner i_comb (
        .clock            (clock),
        .resetn           (resetn),
        .ctrl_i           (ctrl),
        .new_game_i       (new_game_i),
        .red_count_i      (red_count),
        .match_count_i    (match_count),
        .round_over_o     (round_over),
        .red_o            (red_o),
        .white_o          (white_o),
        .feedback_valid_o (feedback_valid_o),
        .score_one_o      (score_one_o),
        .score_two_o      (score_two_o),
        .one_sets_code_o  (one_sets_code_o)
    );

endmodule

/* hw/feedback_combiner.sv */
`timescale 1ns/100ps
`include "mastermind_cfg.svh"

module feedback_combiner
    import mastermind_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  step_ctrl_t ctrl_i,
    input  logic       new_game_i,
    input  peg_count_t red_count_i,
    input  peg_count_t match_count_i,
    output logic       round_over_o,
    output peg_count_t red_o,
    output peg_count_t white_o,
    output logic       feedback_valid_o,
    output score_t     score_one_o,
    output score_t     score_two_o,
    output logic       one_sets_code_o
);

    guess_count_t guess_cnt_q;
    peg_count_t   white_count;
    logic         win;
    logic         last_guess;

    assign win         = (red_count_i == peg_count_t'(`MM_SLOTS));
    assign last_guess  = (guess_cnt_q == guess_count_t'(`MM_MAX_GUESSES - 1));
    assign white_count = match_count_i - red_count_i; // Matches never below red

    // Pulse in the result step only
    assign round_over_o = ctrl_i.result && (win || last_guess);

    always_ff @(posedge clock) begin
        if (!resetn || new_game_i) begin
            red_o            <= '0;
            white_o          <= '0;
            feedback_valid_o <= 1'b0;
            score_one_o      <= '0;
            score_two_o      <= '0;
            guess_cnt_q      <= '0;
            one_sets_code_o  <= 1'b1;
        end else begin
            feedback_valid_o <= ctrl_i.result;
            if (ctrl_i.result) begin
                red_o   <= red_count_i;
                white_o <= white_count;

                // Setter scores every guess that misses
                if (!win) begin
                    if (one_sets_code_o) begin
                        score_one_o <= score_one_o + 1'b1;
                    end else begin
                        score_two_o <= score_two_o + 1'b1;
                    end
                end

                if (round_over_o) begin
                    guess_cnt_q     <= '0;
                    one_sets_code_o <= !one_sets_code_o; // Roles swap
                end else begin
                    guess_cnt_q <= guess_cnt_q + 1'b1;
                end
            end
        end
    end

endmodule

/* hw/colour_match_counter.sv */
`timescale 1ns/100ps
`include "mastermind_cfg.svh"

module colour_match_counter
    import mastermind_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  step_ctrl_t ctrl_i,
    input  peg_t       code_peg_i,
    input  code_t      guess_i,
    output peg_count_t match_count_o
);

    logic [`MM_SLOTS-1:0] claimed_q;
    logic [`MM_SLOTS-1:0] claimed_eff;
    logic [`MM_SLOTS-1:0] avail;
    logic [`MM_SLOTS-1:0] pick;
    logic                 found;

    // Claims from an earlier guess do not count
    assign claimed_eff = ctrl_i.clear_counts ? '0 : claimed_q;

    always_comb begin
        avail = '0;
        pick  = '0;
        found = 1'b0;

        for (int i = 0; i < `MM_SLOTS; i++) begin
            avail[i] = (guess_i[i*`MM_COLOUR_W +: `MM_COLOUR_W] == code_peg_i)
                       && !claimed_eff[i];
        end

        // Same slot first, then the lowest free slot
        if (avail[ctrl_i.slot]) begin
            pick[ctrl_i.slot] = 1'b1;
            found             = 1'b1;
        end else begin
            for (int i = 0; i < `MM_SLOTS; i++) begin
                if (avail[i] && !found) begin
                    pick[i] = 1'b1;
                    found   = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            claimed_q     <= '0;
            match_count_o <= '0;
        end else if (ctrl_i.compare_en) begin
            claimed_q <= claimed_eff | pick;
            if (ctrl_i.clear_counts) begin
                match_count_o <= peg_count_t'(found);
            end else begin
                match_count_o <= match_count_o + peg_count_t'(found);
            end
        end
    end

endmodule

/* hw/exact_match_counter.sv */
`timescale 1ns/100ps
`include "mastermind_cfg.svh"

module exact_match_counter
    import mastermind_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  step_ctrl_t ctrl_i,
    input  peg_t       code_peg_i,
    input  code_t      guess_i,
    output peg_count_t red_count_o
);

    peg_t guess_peg;
    logic hit;

    // Guess peg in the same slot as the code peg
    assign guess_peg = guess_i[ctrl_i.slot*`MM_COLOUR_W +: `MM_COLOUR_W];
    assign hit       = (guess_peg == code_peg_i);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            red_count_o <= '0;
        end else if (ctrl_i.compare_en) begin
            if (ctrl_i.clear_counts) begin
                red_count_o <= peg_count_t'(hit); // Restart with the first step
            end else begin
                red_count_o <= red_count_o + peg_count_t'(hit);
            end
        end
    end

endmodule

/* hw/peg_store.sv */
`timescale 1ns/100ps
`include "mastermind_cfg.svh"

module peg_store
    import mastermind_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  step_ctrl_t ctrl_i,
    input  peg_t       colour_i,
    output peg_t       code_peg_o,
    output code_t      guess_o
);

    code_t code_q;
    code_t guess_q;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            code_q  <= '0;
            guess_q <= '0;
        end else begin
            if (ctrl_i.code_wr) begin
                code_q[ctrl_i.slot*`MM_COLOUR_W +: `MM_COLOUR_W] <= colour_i;
            end
            if (ctrl_i.guess_wr) begin
                guess_q[ctrl_i.slot*`MM_COLOUR_W +: `MM_COLOUR_W] <= colour_i;
            end
        end
    end

    // Code peg under comparison
    assign code_peg_o = code_q[ctrl_i.slot*`MM_COLOUR_W +: `MM_COLOUR_W];

    assign guess_o = guess_q; // Whole guess, counters pick slots

endmodule

/* hw/game_ctrl.sv */
`timescale 1ns/100ps
`include "mastermind_cfg.svh"

module game_ctrl
    import mastermind_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  logic       load_i,
    input  logic       new_game_i,
    input  logic       round_over_i,
    output step_ctrl_t ctrl_o
);

    game_state_t state_q;
    game_state_t state_d;
    slot_idx_t   slot_q;
    slot_idx_t   slot_d;
    logic        last_slot;

    assign last_slot = (slot_q == slot_idx_t'(`MM_SLOTS - 1));

    always_comb begin
        state_d     = state_q;
        slot_d      = slot_q;
        ctrl_o      = '0;
        ctrl_o.slot = slot_q;

        case (state_q)
            CODE_ENTRY: begin
                // Peg taken on the first edge that sees the button
                if (load_i) begin
                    ctrl_o.code_wr = 1'b1;
                    state_d        = CODE_RELEASE;
                end
            end

            CODE_RELEASE: begin
                if (!load_i) begin
                    slot_d  = last_slot ? '0 : slot_q + 1'b1;
                    state_d = last_slot ? GUESS_ENTRY : CODE_ENTRY;
                end
            end

            GUESS_ENTRY: begin
                if (load_i) begin
                    ctrl_o.guess_wr = 1'b1;
                    state_d         = GUESS_RELEASE;
                end
            end

            GUESS_RELEASE: begin
                if (!load_i) begin
                    slot_d  = last_slot ? '0 : slot_q + 1'b1;
                    state_d = last_slot ? COMPARE : GUESS_ENTRY;
                end
            end

            COMPARE: begin
                // One code slot per cycle
                ctrl_o.compare_en   = 1'b1;
                ctrl_o.clear_counts = (slot_q == '0);
                slot_d              = last_slot ? '0 : slot_q + 1'b1;
                if (last_slot) begin
                    state_d = RESULT;
                end
            end

            RESULT: begin
                ctrl_o.result = 1'b1;
                state_d       = round_over_i ? CODE_ENTRY : GUESS_ENTRY; // Roles swap on round over
            end

            default: begin
                state_d = CODE_ENTRY;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state_q <= CODE_ENTRY;
            slot_q  <= '0;
        end else if (new_game_i) begin
            state_q <= CODE_ENTRY;
            slot_q  <= '0;
        end else begin
            state_q <= state_d;
            slot_q  <= slot_d;
        end
    end

endmodule

/* hw/mastermind_pkg.sv */
`include "mastermind_cfg.svh"

package mastermind_pkg;

    typedef logic [`MM_COLOUR_W-1:0] peg_t;

    // Slot 0 in the low bits
    typedef logic [`MM_SLOTS*`MM_COLOUR_W-1:0] code_t;

    typedef logic [$clog2(`MM_SLOTS)-1:0] slot_idx_t;

    // Red, white or match count, 0 to MM_SLOTS
    typedef logic [$clog2(`MM_SLOTS+1)-1:0] peg_count_t;

    typedef logic [$clog2(`MM_MAX_GUESSES)-1:0] guess_count_t;
    typedef logic [`MM_SCORE_W-1:0] score_t;

    typedef enum logic [2:0] {
        CODE_ENTRY,
        CODE_RELEASE,
        GUESS_ENTRY,
        GUESS_RELEASE,
        COMPARE,
        RESULT
    } game_state_t;

    // Step controls from the FSM to the datapath
    typedef struct packed {
        logic      code_wr;
        logic      guess_wr;
        slot_idx_t slot;         // Slot written or compared
        logic      compare_en;
        logic      clear_counts; // First compare step
        logic      result;
    } step_ctrl_t;

endpackage

/* hw/mastermind_cfg.svh */
`ifndef MASTERMIND_CFG_SVH
`define MASTERMIND_CFG_SVH

// Board geometry

// Pegs in one code or guess
`define MM_SLOTS 4

// Eight colours per peg
`define MM_COLOUR_W 3

// Rules of a round

// Guesses before the round is lost
`define MM_MAX_GUESSES 8

// Scores wrap at 16
`define MM_SCORE_W 4

`endif
